/* Bender.yml */
package:
  name: mem_subsys

export_include_dirs:
  - rtl

sources:
  - rtl/memPkg.sv
  - rtl/byteRam.sv
  - rtl/memArbiter.sv
  - rtl/memSequencer.sv
  - rtl/memSubsys.sv
  - target: simulation
    files:
      - sim/tbMemSubsys.sv

/* list.f */
+incdir+rtl
rtl/memPkg.sv
rtl/byteRam.sv
rtl/memArbiter.sv
rtl/memSequencer.sv
rtl/memSubsys.sv
sim/tbMemSubsys.sv

/* rtl/byteRam.sv */
`include "mem_defines.svh"

module byteRam #(
    parameter int DEPTH = `MEM_DEPTH
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] i_addr,
    input  logic                     i_we,
    input  logic [7:0]               i_wdata,
    output logic [7:0]               o_rdata
);

    logic [7:0] mem [DEPTH];

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

/* rtl/memArbiter.sv */
`include "mem_defines.svh"

module memArbiter
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_fetchReq,
    input  logic [`MEM_ADDR_W-1:0] i_fetchAddr,
    input  logic                   i_dataReq,
    input  memOp_e                 i_dataOp,
    input  memLen_e                i_dataLen,
    input  logic [`MEM_ADDR_W-1:0] i_dataAddr,
    input  logic [31:0]            i_dataWdata,
    input  memResp_t               i_resp,
    output memReq_t                o_req,
    output logic                   o_fetchDone,
    output logic [31:0]            o_fetchInst,
    output logic                   o_dataDone,
    output logic [31:0]            o_dataRdata
);

    logic                   reqValid;
    memOp_e                 reqOp;
    memLen_e                reqLen;
    logic [`MEM_ADDR_W-1:0] reqAddr;
    logic [31:0]            reqWdata;
    logic                   fetchAck;
    logic                   dataAck;
    logic                   ownerData;
    logic                   fetchElig;
    logic                   dataElig;
    logic                   grantFetch;
    logic                   grantData;

    // a client is served once per request edge
    assign fetchElig = i_fetchReq && !fetchAck;
    assign dataElig  = i_dataReq && !dataAck;

    // data wins a tie
    // the data ack holds off a regrant so a waiting fetch goes next
    assign grantFetch = !reqValid && fetchElig && !dataElig;
    assign grantData  = !reqValid && dataElig && !grantFetch;

    always_comb begin
        o_req.op    = reqOp;
        o_req.len   = reqLen;
        o_req.addr  = reqAddr;
        o_req.wdata = reqWdata;
        o_req.valid = reqValid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reqValid    <= 1'b0;
            fetchAck    <= 1'b0;
            dataAck     <= 1'b0;
            ownerData   <= 1'b0;
            o_fetchDone <= 1'b0;
            o_dataDone  <= 1'b0;
        end else begin
            o_fetchDone <= i_resp.done && !ownerData;
            o_dataDone  <= i_resp.done && ownerData;
            if (!i_fetchReq) begin
                fetchAck <= 1'b0;
            end
            if (!i_dataReq) begin
                dataAck <= 1'b0;
            end
            if (reqValid) begin
                if (i_resp.done) begin
                    reqValid <= 1'b0;
                end
            end else if (grantFetch) begin
                reqValid  <= 1'b1;
                ownerData <= 1'b0;
                fetchAck  <= 1'b1;
            end else if (grantData) begin
                reqValid  <= 1'b1;
                ownerData <= 1'b1;
                dataAck   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantFetch) begin
            reqOp    <= OP_FETCH;
            reqLen   <= LEN_WORD;
            reqAddr  <= i_fetchAddr;
            reqWdata <= '0;
        end else if (grantData) begin
            reqOp    <= i_dataOp;
            reqLen   <= i_dataLen;
            reqAddr  <= i_dataAddr;
            reqWdata <= i_dataWdata;
        end
        if (i_resp.done && !ownerData) begin
            o_fetchInst <= i_resp.rdata;
        end
        if (i_resp.done && ownerData) begin
            o_dataRdata <= i_resp.rdata;
        end
    end

endmodule

/* rtl/memPkg.sv */
`include "mem_defines.svh"

package memPkg;

    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } memOp_e;

    // byte count 1, 2 or 4
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } memLen_e;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_READ  = 2'd1,
        S_WRITE = 2'd2,
        S_DONE  = 2'd3
    } seqState_e;

    typedef struct packed {
        memOp_e                 op;
        memLen_e                len;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
        logic                   valid;
    } memReq_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } memResp_t;

endpackage

/* rtl/memSequencer.sv */
`include "mem_defines.svh"

module memSequencer
    import memPkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_rdy,
    input  logic                          i_ioFull,
    input  memReq_t                       i_req,
    input  logic [7:0]                    i_ramRdata,
    output memResp_t                      o_resp,
    output logic [$clog2(`MEM_DEPTH)-1:0] o_ramAddr,
    output logic                          o_ramWe,
    output logic [7:0]                    o_ramWdata,
    output logic                          o_ioValid,
    output logic [`MEM_ADDR_W-1:0]        o_ioAddr,
    output logic [7:0]                    o_ioData
);

    localparam int ramAddrW = $clog2(`MEM_DEPTH);

    seqState_e              state;
    logic [1:0]             cnt;
    logic [1:0]             lastIdx;
    logic [1:0]             newLast;
    memOp_e                 curOp;
    logic [`MEM_ADDR_W-1:0] curAddr;
    logic [31:0]            curWdata;
    logic                   curIo;
    logic [31:0]            rdBuf;
    logic [31:0]            rdWord;
    logic [1:0]             capIdx;
    logic                   capVld;
    logic                   start;
    logic                   wrStep;
    logic                   ioFire;
    logic [`MEM_ADDR_W-1:0] byteAddr;
    logic [7:0]             wrByte;

    assign start = (state == S_IDLE) && i_rdy && i_req.valid;

    // index of the final byte
    always_comb begin
        if (i_req.op == OP_FETCH) begin
            newLast = 2'd3;
        end else begin
            case (i_req.len)
                LEN_BYTE: newLast = 2'd0;
                LEN_HALF: newLast = 2'd1;
                default:  newLast = 2'd3;
            endcase
        end
    end

    assign byteAddr = curAddr + cnt;
    assign wrByte   = curWdata[{cnt, 3'b000} +: 8];

    // IO bytes wait on a full buffer
    assign wrStep = (state == S_WRITE) && i_rdy && !(curIo && i_ioFull);
    assign ioFire = wrStep && curIo;

    assign o_ramAddr  = byteAddr[ramAddrW-1:0];
    assign o_ramWe    = wrStep && !curIo;
    assign o_ramWdata = wrByte;

    // last byte comes straight from the RAM output in S_DONE
    always_comb begin
        rdWord = rdBuf;
        if (curOp != OP_STORE) begin
            rdWord[{cnt, 3'b000} +: 8] = i_ramRdata;
        end
    end

    always_comb begin
        o_resp.done  = (state == S_DONE) && i_rdy;
        o_resp.rdata = rdWord;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= 2'd0;
            capVld    <= 1'b0;
            capIdx    <= 2'd0;
            o_ioValid <= 1'b0;
        end else begin
            // RAM returns the byte addressed one clock earlier, stalled or not
            capVld    <= (state == S_READ);
            capIdx    <= cnt;
            o_ioValid <= ioFire;
            if (i_rdy) begin
                case (state)
                    S_IDLE: begin
                        if (i_req.valid) begin
                            cnt <= 2'd0;
                            if (i_req.op == OP_STORE) begin
                                state <= S_WRITE;
                            end else begin
                                state <= S_READ;
                            end
                        end
                    end
                    S_READ: begin
                        if (cnt == lastIdx) begin
                            state <= S_DONE;
                        end else begin
                            cnt <= cnt + 2'd1;
                        end
                    end
                    S_WRITE: begin
                        if (wrStep) begin
                            if (cnt == lastIdx) begin
                                state <= S_DONE;
                            end else begin
                                cnt <= cnt + 2'd1;
                            end
                        end
                    end
                    S_DONE: begin
                        state <= S_IDLE;
                    end
                    default: begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            curOp    <= i_req.op;
            curAddr  <= i_req.addr;
            curWdata <= i_req.wdata;
            curIo    <= (i_req.addr >= `IO_BASE);
            lastIdx  <= newLast;
            // zero extension for short loads
            rdBuf    <= '0;
        end else if (capVld) begin
            rdBuf[{capIdx, 3'b000} +: 8] <= i_ramRdata;
        end
        if (ioFire) begin
            o_ioAddr <= byteAddr;
            o_ioData <= wrByte;
        end
    end

endmodule

/* rtl/memSubsys.sv */
`include "mem_defines.svh"

module memSubsys
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioFull,
    input  logic                   i_fetchReq,
    input  logic [`MEM_ADDR_W-1:0] i_fetchAddr,
    output logic                   o_fetchDone,
    output logic [31:0]            o_fetchInst,
    input  logic                   i_dataReq,
    input  memOp_e                 i_dataOp,
    input  memLen_e                i_dataLen,
    input  logic [`MEM_ADDR_W-1:0] i_dataAddr,
    input  logic [31:0]            i_dataWdata,
    output logic                   o_dataDone,
    output logic [31:0]            o_dataRdata,
    output logic                   o_ioValid,
    output logic [`MEM_ADDR_W-1:0] o_ioAddr,
    output logic [7:0]             o_ioData
);

    memReq_t                       req;
    memResp_t                      resp;
    logic [$clog2(`MEM_DEPTH)-1:0] ramAddr;
    logic                          ramWe;
    logic [7:0]                    ramWdata;
    logic [7:0]                    ramRdata;

    memArbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_fetchReq  (i_fetchReq),
        .i_fetchAddr (i_fetchAddr),
        .i_dataReq   (i_dataReq),
        .i_dataOp    (i_dataOp),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .i_resp      (resp),
        .o_req       (req),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

    memSequencer sequencer (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (i_rdy),
        .i_ioFull   (i_ioFull),
        .i_req      (req),
        .i_ramRdata (ramRdata),
        .o_resp     (resp),
        .o_ramAddr  (ramAddr),
        .o_ramWe    (ramWe),
        .o_ramWdata (ramWdata),
        .o_ioValid  (o_ioValid),
        .o_ioAddr   (o_ioAddr),
        .o_ioData   (o_ioData)
    );

    byteRam #(
        .DEPTH (`MEM_DEPTH)
    ) ram (
        .clk     (clk),
        .i_addr  (ramAddr),
        .i_we    (ramWe),
        .i_wdata (ramWdata),
        .o_rdata (ramRdata)
    );

endmodule

/* rtl/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address, one bit wider than the RAM index
`define MEM_ADDR_W 17

// RAM size in bytes, addresses below this hit the RAM
`define MEM_DEPTH 65536

// first IO address
`define IO_BASE 17'h10000

`endif

/* sim/tbMemSubsys.sv */
`include "mem_defines.svh"

module tbMemSubsys
    import memPkg::*;
();

    localparam int numTrans = 260;
    localparam logic [16:0] regionBase = 17'h01000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   i_rdy;
    logic                   i_ioFull;
    logic                   i_fetchReq;
    logic [`MEM_ADDR_W-1:0] i_fetchAddr;
    logic                   o_fetchDone;
    logic [31:0]            o_fetchInst;
    logic                   i_dataReq;
    memOp_e                 i_dataOp;
    memLen_e                i_dataLen;
    logic [`MEM_ADDR_W-1:0] i_dataAddr;
    logic [31:0]            i_dataWdata;
    logic                   o_dataDone;
    logic [31:0]            o_dataRdata;
    logic                   o_ioValid;
    logic [`MEM_ADDR_W-1:0] o_ioAddr;
    logic [7:0]             o_ioData;

    logic [7:0]             model [0:65535];
    logic [`MEM_ADDR_W-1:0] ioAddrQ [$];
    logic [7:0]             ioDataQ [$];
    bit                     stallOn = 1'b0;
    int                     errCount = 0;

    memSubsys dut (.*);

    always #4 clk = ~clk;

    // random ready gaps only during the stall phase
    always @(negedge clk) begin
        i_rdy = stallOn ? ($urandom % 4 != 0) : 1'b1;
    end

    always @(negedge clk) begin
        if (!rst && o_ioValid) begin
            ioAddrQ.push_back(o_ioAddr);
            ioDataQ.push_back(o_ioData);
        end
    end

    task automatic failNow(input string msg);
        errCount++;
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            failNow($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    assert property (@(posedge clk) disable iff (rst) o_dataDone |=> !o_dataDone)
        else failNow("data done stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (rst) o_fetchDone |=> !o_fetchDone)
        else failNow("fetch done stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (rst)
        !$past(i_rdy) |-> !(o_fetchDone || o_dataDone || o_ioValid))
        else failNow("done or IO strobe appeared right after a stalled edge");
    assert property (@(posedge clk) disable iff (rst) $past(i_ioFull) |-> !o_ioValid)
        else failNow("IO strobe issued while the IO buffer was full");

    initial begin
        #((numTrans * 40 + 1000) * 8);
        failNow("watchdog expired, a transfer never completed");
    end

    function automatic int nBytes(input memLen_e len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // little-endian, zero-extended
    function automatic logic [31:0] modelRead(input logic [16:0] addr, input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r[8*k +: 8] = model[addr[15:0] + k];
        end
        return r;
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic dataAccess(input memOp_e op, input memLen_e len, input logic [16:0] addr,
                              input logic [31:0] wdata, input bit timed,
                              output logic [31:0] rdata, output time doneAt);
        int cycles;
        cycles      = 0;
        i_dataOp    = op;
        i_dataLen   = len;
        i_dataAddr  = addr;
        i_dataWdata = wdata;
        i_dataReq   = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_dataDone);
        doneAt    = $time;
        rdata     = o_dataRdata;
        i_dataReq = 1'b0;
        if (timed) begin
            checkValue("data latency", nBytes(len) + 3, cycles);
        end
        if (op == OP_STORE && addr < `IO_BASE) begin
            for (int k = 0; k < nBytes(len); k++) begin
                model[addr[15:0] + k] = wdata[8*k +: 8];
            end
        end
        @(negedge clk);
    endtask

    task automatic fetchAccess(input logic [16:0] addr, input bit timed,
                               output logic [31:0] inst, output time doneAt);
        int cycles;
        cycles      = 0;
        i_fetchAddr = addr;
        i_fetchReq  = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_fetchDone);
        doneAt     = $time;
        inst       = o_fetchInst;
        i_fetchReq = 1'b0;
        if (timed) begin
            checkValue("fetch latency", 7, cycles);
        end
        @(negedge clk);
    endtask

    task automatic loadCheck(input string name, input memLen_e len, input logic [16:0] addr,
                             input bit timed);
        logic [31:0] rd;
        time         t;
        dataAccess(OP_LOAD, len, addr, '0, timed, rd, t);
        checkValue(name, modelRead(addr, nBytes(len)), rd);
    endtask

    // one strobe per byte, RAM behind the alias untouched
    task automatic ioStoreCheck(input memLen_e len, input logic [16:0] addr,
                                input logic [31:0] wd, input bit timed);
        logic [31:0] rd;
        time         t;
        ioAddrQ.delete();
        ioDataQ.delete();
        dataAccess(OP_STORE, len, addr, wd, timed, rd, t);
        checkValue("io strobe count", nBytes(len), ioAddrQ.size());
        for (int k = 0; k < nBytes(len); k++) begin
            checkValue("io addr", addr + k, ioAddrQ[k]);
            checkValue("io data", wd[8*k +: 8], ioDataQ[k]);
        end
        loadCheck("io ram untouched", LEN_WORD, addr - `IO_BASE, timed);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [16:0] addr;
        logic [31:0] wd;
        memLen_e     len;
        time         tData;
        time         tData2;
        time         tFetch;

        void'($urandom(32'hb08b763b));
        rst         = 1'b1;
        i_rdy       = 1'b1;
        i_ioFull    = 1'b0;
        i_fetchReq  = 1'b0;
        i_fetchAddr = '0;
        i_dataReq   = 1'b0;
        i_dataOp    = OP_LOAD;
        i_dataLen   = LEN_BYTE;
        i_dataAddr  = '0;
        i_dataWdata = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // fill the test region so every read hits known bytes
        for (int i = 0; i < 64; i++) begin
            dataAccess(OP_STORE, LEN_WORD, regionBase + 4 * i, $urandom, 1'b1, rd, tData);
        end

        for (int i = 0; i < 16; i++) begin
            addr = regionBase + $urandom % 253;
            fetchAccess(addr, 1'b1, rd, tFetch);
            checkValue("fetch", modelRead(addr, 4), rd);
        end

        for (int i = 0; i < 40; i++) begin
            len = memLen_e'($urandom % 3);
            loadCheck("load", len, regionBase + $urandom % 253, 1'b1);
        end

        // read back a window around each store
        for (int i = 0; i < 20; i++) begin
            len  = memLen_e'($urandom % 3);
            addr = regionBase + 2 + $urandom % 248;
            dataAccess(OP_STORE, len, addr, $urandom, 1'b1, rd, tData);
            loadCheck("store readback low", LEN_WORD, addr - 2, 1'b1);
            loadCheck("store readback high", LEN_WORD, addr + 2, 1'b1);
        end

        // fetch waits behind one data transfer, then beats the next one
        for (int i = 0; i < 4; i++) begin
            addr = regionBase + $urandom % 253;
            fork
                begin
                    dataAccess(OP_LOAD, LEN_WORD, regionBase + 4 * i, '0, 1'b0, rd2, tData);
                    checkValue("contention data", modelRead(regionBase + 4 * i, 4), rd2);
                    dataAccess(OP_LOAD, LEN_HALF, regionBase + 8 * i, '0, 1'b0, rd2, tData2);
                    checkValue("contention data 2", modelRead(regionBase + 8 * i, 2), rd2);
                end
                begin
                    fetchAccess(addr, 1'b0, rd, tFetch);
                    checkValue("contention fetch", modelRead(addr, 4), rd);
                end
            join
            checkValue("data before fetch", 1, tData < tFetch);
            checkValue("fetch before second data", 1, tFetch < tData2);
        end

        stallOn = 1'b1;
        for (int i = 0; i < 30; i++) begin
            len  = memLen_e'($urandom % 3);
            addr = regionBase + $urandom % 253;
            case ($urandom % 3)
                0: dataAccess(OP_STORE, len, addr, $urandom, 1'b0, rd, tData);
                1: loadCheck("stall load", len, addr, 1'b0);
                default: begin
                    fetchAccess(addr, 1'b0, rd, tFetch);
                    checkValue("stall fetch", modelRead(addr, 4), rd);
                end
            endcase
        end

        // IO stores with ready gaps
        for (int i = 0; i < 8; i++) begin
            len  = memLen_e'($urandom % 3);
            addr = `IO_BASE + regionBase + $urandom % 253;
            wd   = $urandom;
            ioStoreCheck(len, addr, wd, 1'b0);
        end
        stallOn = 1'b0;
        @(negedge clk);

        // IO stores alias a region address to check that RAM stays untouched
        for (int i = 0; i < 4; i++) begin
            len  = memLen_e'($urandom % 3);
            addr = `IO_BASE + regionBase + $urandom % 253;
            wd   = $urandom;
            ioStoreCheck(len, addr, wd, 1'b1);
        end

        i_ioFull = 1'b1;
        fork
            dataAccess(OP_STORE, LEN_WORD, `IO_BASE + regionBase, $urandom, 1'b0, rd, tData);
            begin
                repeat (20) begin
                    @(negedge clk);
                    checkValue("done while io full", 0, o_dataDone);
                end
                i_ioFull = 1'b0;
            end
        join

        if (errCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
